//--- build.f
decoder_pkg.sv
ctrl_flow_decoder.sv
lsu_decoder.sv
alu_decoder.sv
system_decoder.sv
rv32_decoder.sv
tb_rv32_decoder.sv

//--- run_sim.sh
#!/bin/sh
# build the decoder testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module tb_rv32_decoder -f build.f
out=$(./obj_dir/Vtb_rv32_decoder 2>&1) || true
echo "$out"
if echo "$out" | grep -q "TESTBENCH PASSED"; then
  exit 0
fi
exit 1

//--- decoder_vectors.txt
// insn_side(illc jmux bmux dwe)_exc(ill ebrk mret ecall flush)_alu_opa opb imma immb
// _md(en op sign)_we csracc csrop csrst_req dwe type sext_jb(jump branch)
00510093_0_00_18_0210_000_1000_0020_0
00517093_0_00_15_0210_000_1000_0000_0
00311093_0_00_27_0210_000_1000_0010_0
40315093_0_00_24_0210_000_1000_0010_0
02311093_0_10_27_0210_000_1000_0010_0
003100b3_0_00_18_0010_000_1000_0020_0
403100b3_0_00_19_0010_000_1000_0020_0
123450b7_0_00_18_2212_000_1000_0010_0
00001097_0_00_18_1212_000_1000_0010_0
00412083_0_00_03_0010_000_1000_1001_0
00415083_0_00_03_0010_000_1000_1010_0
00413083_0_10_03_0010_000_0000_0001_0
00312423_0_00_03_0011_000_0000_1100_0
00313423_0_10_03_0011_000_0000_0000_0
008000ef_0_00_18_1213_000_1000_0020_2
008000ef_4_00_18_121c_000_0000_0020_2
000100e7_0_00_18_1213_000_1000_0020_2
000100e7_4_00_18_0210_000_0000_0020_2
000110e7_0_10_18_1213_000_0000_0010_0
00310463_0_00_18_121d_000_0000_0020_1
00310463_2_00_0c_0010_000_0000_0020_1
00316463_2_00_01_0010_000_0000_0000_1
00312463_2_10_0b_0010_000_0000_0000_1
00000073_0_02_03_0010_000_0000_0020_0
00100073_0_08_03_0010_000_0000_0020_0
30200073_0_04_03_0010_000_0000_0020_0
10500073_0_01_03_0010_000_0000_0020_0
300110f3_0_00_03_0000_000_1111_0010_0
3412e0f3_0_00_03_2000_000_1120_0000_0
300140f3_0_10_03_2000_000_1100_0020_0
023100b3_0_00_18_0010_200_1000_0020_0
023140b3_0_00_18_0010_123_1000_0020_0
00510093_8_10_18_0210_000_1000_0020_0
00312423_1_00_03_0011_000_0000_0100_0
300110f3_1_00_03_0000_000_0101_0010_0
023100b3_1_00_18_0010_000_0000_0020_0
// end marker
ffffffff_f_ff_ff_ffff_fff_ffff_ffff_f

//--- tb_rv32_decoder.sv
// testbench for rv32_decoder, vectors from decoder_vectors.txt (run from project root)
// stops at the first mismatch; vector table must end with an all-ones line
module tb_rv32_decoder import decoder_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  logic clk, rst_n_i, instr_valid_i, illegal_c_insn_i;
  logic jump_mux_i, branch_mux_i, deassert_we_i;
  insn_t instr_rdata_i;
  logic ex_valid_o, illegal_insn_o, ebrk_insn_o, mret_insn_o, ecall_insn_o, pipe_flush_o;
  alu_op_e alu_operator_o;
  op_a_sel_e alu_op_a_mux_sel_o;
  op_b_sel_e alu_op_b_mux_sel_o;
  imm_a_sel_e imm_a_mux_sel_o;
  imm_b_sel_e imm_b_mux_sel_o;
  logic mult_int_en_o, div_int_en_o, regfile_we_o, csr_access_o, csr_status_o;
  md_op_e multdiv_operator_o;
  md_sign_t multdiv_signed_mode_o;
  csr_op_e csr_op_o;
  logic data_req_o, data_we_o, data_sign_extension_o, jump_in_id_o, branch_in_id_o;
  data_type_e data_type_o;

  logic [115:0] vec_mem [0:63];  // one packed line per vector
  logic [31:0] lcg_state;

  rv32_decoder #(.RV32M(1)) dut0 (.*);

  always #10 clk = ~clk;  // 20 ns period

  // global guard
  initial begin
    #100us;
    $display("Error: simulation ran past its time limit");
    $display("TESTBENCH FAILED");
    $fatal(1, "watchdog");
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic is_legal_opcode(input logic [6:0] opc);
    case (opc)
      OPCODE_LOAD, OPCODE_STORE, OPCODE_BRANCH, OPCODE_JALR, OPCODE_JAL,
      OPCODE_OPIMM, OPCODE_OP, OPCODE_LUI, OPCODE_AUIPC, OPCODE_SYSTEM: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act == exp) else begin
      $display("** Error: %s expected 0x%0h, got 0x%0h", name, exp, act);
      $display("TESTBENCH FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic fail_with(input string what);
    $display("Error: %s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "%s", what);
  endtask

  // strobe one word, then wait for ex_valid_o; outputs sampled 2 ns after the edge
  task automatic strobe_insn(input insn_t w, input logic [3:0] side);
    int cycles;
    cycles = 0;
    @(posedge clk);
    #2;
    instr_rdata_i = w;
    {illegal_c_insn_i, jump_mux_i, branch_mux_i, deassert_we_i} = side;
    instr_valid_i = 1'b1;
    @(posedge clk);
    #2;
    instr_valid_i = 1'b0;
    while (!ex_valid_o && cycles < 5) begin
      @(posedge clk);
      #2;
      cycles++;
    end
    if (!ex_valid_o) begin
      fail_with("ex_valid_o never rose after a strobe");
    end else if (cycles != 0) begin
      fail_with("ex_valid_o rose later than one cycle after the strobe");
    end
  endtask

  task automatic expect_valid_drop();
    @(posedge clk);
    #2;
    check_val("ex_valid_o", 32'd0, 32'(ex_valid_o));  // one cycle only
  endtask

  task automatic check_reset_state();
    check_val("ex_valid_o", 32'd0, 32'(ex_valid_o));
    check_val("illegal_insn_o", 32'd0, 32'(illegal_insn_o));
    check_val("ebrk_insn_o", 32'd0, 32'(ebrk_insn_o));
    check_val("mret_insn_o", 32'd0, 32'(mret_insn_o));
    check_val("ecall_insn_o", 32'd0, 32'(ecall_insn_o));
    check_val("pipe_flush_o", 32'd0, 32'(pipe_flush_o));
    check_val("regfile_we_o", 32'd0, 32'(regfile_we_o));
    check_val("mult_int_en_o", 32'd0, 32'(mult_int_en_o));
    check_val("div_int_en_o", 32'd0, 32'(div_int_en_o));
    check_val("data_req_o", 32'd0, 32'(data_req_o));
    check_val("data_we_o", 32'd0, 32'(data_we_o));
    check_val("csr_access_o", 32'd0, 32'(csr_access_o));
    check_val("csr_op_o", 32'(CSR_OP_NONE), 32'(csr_op_o));
    check_val("jump_in_id_o", 32'd0, 32'(jump_in_id_o));
    check_val("branch_in_id_o", 32'd0, 32'(branch_in_id_o));
  endtask

  ////////////////////////////////////////////////////////////////////
  // table driven checks
  ////////////////////////////////////////////////////////////////////
  task automatic run_vectors();
    logic [115:0] v;
    logic done;
    done = 1'b0;
    $readmemh("decoder_vectors.txt", vec_mem);
    for (int i = 0; i < 64 && !done; i++) begin
      v = vec_mem[i[5:0]];
      if (v == '1) begin
        done = 1'b1;  // end marker
      end else begin
        strobe_insn(v[115:84], v[83:80]);
        check_val("illegal_insn_o", 32'(v[76]), 32'(illegal_insn_o));
        check_val("ebrk_insn_o", 32'(v[75]), 32'(ebrk_insn_o));
        check_val("mret_insn_o", 32'(v[74]), 32'(mret_insn_o));
        check_val("ecall_insn_o", 32'(v[73]), 32'(ecall_insn_o));
        check_val("pipe_flush_o", 32'(v[72]), 32'(pipe_flush_o));
        check_val("alu_operator_o", 32'(v[69:64]), 32'(alu_operator_o));
        check_val("alu_op_a_mux_sel_o", 32'(v[62:60]), 32'(alu_op_a_mux_sel_o));
        check_val("alu_op_b_mux_sel_o", 32'(v[58:56]), 32'(alu_op_b_mux_sel_o));
        check_val("imm_a_mux_sel_o", 32'(v[52]), 32'(imm_a_mux_sel_o));
        check_val("imm_b_mux_sel_o", 32'(v[51:48]), 32'(imm_b_mux_sel_o));
        check_val("mult_int_en_o", 32'(v[45]), 32'(mult_int_en_o));
        check_val("div_int_en_o", 32'(v[44]), 32'(div_int_en_o));
        check_val("multdiv_operator_o", 32'(v[41:40]), 32'(multdiv_operator_o));
        check_val("multdiv_signed_mode_o", 32'(v[37:36]), 32'(multdiv_signed_mode_o));
        check_val("regfile_we_o", 32'(v[32]), 32'(regfile_we_o));
        check_val("csr_access_o", 32'(v[28]), 32'(csr_access_o));
        check_val("csr_op_o", 32'(v[25:24]), 32'(csr_op_o));
        check_val("csr_status_o", 32'(v[20]), 32'(csr_status_o));
        check_val("data_req_o", 32'(v[16]), 32'(data_req_o));
        check_val("data_we_o", 32'(v[12]), 32'(data_we_o));
        check_val("data_type_o", 32'(v[9:8]), 32'(data_type_o));
        check_val("data_sign_extension_o", 32'(v[4]), 32'(data_sign_extension_o));
        check_val("jump_in_id_o", 32'(v[1]), 32'(jump_in_id_o));
        check_val("branch_in_id_o", 32'(v[0]), 32'(branch_in_id_o));
        expect_valid_drop();
      end
    end
    if (!done) fail_with("vectors file has no end marker");
  endtask

  // random words with an unassigned major opcode
  task automatic run_random_illegal();
    insn_t w;
    logic [6:0] opc;
    for (int n = 0; n < 20; n++) begin
      lcg_state = lcg_next(lcg_state);
      w = {lcg_state[15:0], lcg_state[31:16]};  // low LCG bits are weak
      opc = w[6:0];
      while (is_legal_opcode(opc)) opc = opc + 7'd1;
      w[6:0] = opc;
      strobe_insn(w, 4'h0);
      check_val("illegal_insn_o", 32'd1, 32'(illegal_insn_o));
      check_val("regfile_we_o", 32'd0, 32'(regfile_we_o));
      check_val("mult_int_en_o", 32'd0, 32'(mult_int_en_o));
      check_val("div_int_en_o", 32'd0, 32'(div_int_en_o));
      check_val("data_req_o", 32'd0, 32'(data_req_o));
      check_val("data_we_o", 32'd0, 32'(data_we_o));
      check_val("csr_access_o", 32'd0, 32'(csr_access_o));
      check_val("jump_in_id_o", 32'd0, 32'(jump_in_id_o));
      check_val("branch_in_id_o", 32'd0, 32'(branch_in_id_o));
      expect_valid_drop();
    end
  endtask

  // jump and branch flags dropped while stalled
  task automatic verify_stall_gating();
    strobe_insn(32'h008000ef, 4'b0001);  // jal x1, link phase
    check_val("illegal_insn_o", 32'd0, 32'(illegal_insn_o));
    check_val("regfile_we_o", 32'd0, 32'(regfile_we_o));
    check_val("jump_in_id_o", 32'd0, 32'(jump_in_id_o));
    expect_valid_drop();
    strobe_insn(32'h00310463, 4'b0011);  // beq, compare phase
    check_val("illegal_insn_o", 32'd0, 32'(illegal_insn_o));
    check_val("alu_operator_o", 32'(ALU_EQ), 32'(alu_operator_o));  // not gated
    check_val("branch_in_id_o", 32'd0, 32'(branch_in_id_o));
    expect_valid_drop();
  endtask

  initial begin
    clk = 1'b0;
    rst_n_i = 1'b0;
    instr_valid_i = 1'b0;
    instr_rdata_i = '0;
    illegal_c_insn_i = 1'b0;
    jump_mux_i = 1'b0;
    branch_mux_i = 1'b0;
    deassert_we_i = 1'b0;
    lcg_state = 32'd72020;
    repeat (4) @(posedge clk);
    #2;
    rst_n_i = 1'b1;
    @(posedge clk);
    #2;
    check_reset_state();  // nothing strobed yet
    run_vectors();
    run_random_illegal();
    verify_stall_gating();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- rv32_decoder.sv
// RV32IM instruction decoder with registered ID/EX controls
// one instruction per instr_valid_i strobe, no back-pressure; results valid
// for the single cycle of ex_valid_o and held until the next strobe
module rv32_decoder import decoder_pkg::*; #(
  parameter int unsigned RV32M = 1
) (
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic       instr_valid_i,       // single-cycle strobe
  input  insn_t      instr_rdata_i,
  input  logic       illegal_c_insn_i,    // compressed expand failed
  input  logic       jump_mux_i,
  input  logic       branch_mux_i,
  input  logic       deassert_we_i,       // stall, drop side effects
  output logic       ex_valid_o,
  output logic       illegal_insn_o,
  output logic       ebrk_insn_o,
  output logic       mret_insn_o,
  output logic       ecall_insn_o,
  output logic       pipe_flush_o,
  output alu_op_e    alu_operator_o,
  output op_a_sel_e  alu_op_a_mux_sel_o,
  output op_b_sel_e  alu_op_b_mux_sel_o,
  output imm_a_sel_e imm_a_mux_sel_o,
  output imm_b_sel_e imm_b_mux_sel_o,
  output logic       mult_int_en_o,
  output logic       div_int_en_o,
  output md_op_e     multdiv_operator_o,
  output md_sign_t   multdiv_signed_mode_o,
  output logic       regfile_we_o,
  output logic       csr_access_o,
  output csr_op_e    csr_op_o,
  output logic       csr_status_o,
  output logic       data_req_o,
  output logic       data_we_o,
  output data_type_e data_type_o,
  output logic       data_sign_extension_o,
  output logic       jump_in_id_o,
  output logic       branch_in_id_o
);

  // jump / branch group
  logic       cf_hit, cf_illegal, cf_jump, cf_branch, cf_we;
  alu_op_e    cf_alu_op;
  op_a_sel_e  cf_op_a;
  op_b_sel_e  cf_op_b;
  imm_b_sel_e cf_imm_b;
  // load / store group
  logic       ls_hit, ls_illegal, ls_req, ls_we_mem, ls_we, ls_sext;
  data_type_e ls_type;
  imm_b_sel_e ls_imm_b;
  // integer and M group
  logic       al_hit, al_illegal, al_we, al_mult, al_div;
  alu_op_e    al_alu_op;
  op_a_sel_e  al_op_a;
  op_b_sel_e  al_op_b;
  imm_b_sel_e al_imm_b;
  md_op_e     al_md_op;
  md_sign_t   al_md_sign;
  // system group
  logic       sy_hit, sy_illegal, sy_ecall, sy_ebrk, sy_mret, sy_wfi;
  logic       sy_csr_access, sy_csr_status, sy_we;
  csr_op_e    sy_csr_op;
  op_a_sel_e  sy_op_a;
  imm_a_sel_e sy_imm_a;

  // merged, pre-register controls
  logic       d_illegal, d_we, d_mult, d_div, d_req, d_jump, d_branch;
  alu_op_e    d_alu_op;
  op_a_sel_e  d_op_a;
  op_b_sel_e  d_op_b;
  imm_b_sel_e d_imm_b;
  csr_op_e    d_csr_op;

  ctrl_flow_decoder u_ctrl_flow (
    .insn_i         (instr_rdata_i),
    .jump_mux_i     (jump_mux_i),
    .branch_mux_i   (branch_mux_i),
    .hit_o          (cf_hit),
    .illegal_o      (cf_illegal),
    .jump_o         (cf_jump),
    .branch_o       (cf_branch),
    .regfile_we_o   (cf_we),
    .alu_operator_o (cf_alu_op),
    .op_a_sel_o     (cf_op_a),
    .op_b_sel_o     (cf_op_b),
    .imm_b_sel_o    (cf_imm_b)
  );

  lsu_decoder u_lsu (
    .insn_i          (instr_rdata_i),
    .hit_o           (ls_hit),
    .illegal_o       (ls_illegal),
    .data_req_o      (ls_req),
    .data_we_o       (ls_we_mem),
    .regfile_we_o    (ls_we),
    .data_type_o     (ls_type),
    .data_sign_ext_o (ls_sext),
    .imm_b_sel_o     (ls_imm_b)
  );

  alu_decoder #(.RV32M(RV32M)) u_alu (
    .insn_i         (instr_rdata_i),
    .hit_o          (al_hit),
    .illegal_o      (al_illegal),
    .regfile_we_o   (al_we),
    .alu_operator_o (al_alu_op),
    .op_a_sel_o     (al_op_a),
    .op_b_sel_o     (al_op_b),
    .imm_b_sel_o    (al_imm_b),
    .mult_en_o      (al_mult),
    .div_en_o       (al_div),
    .md_operator_o  (al_md_op),
    .md_signed_o    (al_md_sign)
  );

  system_decoder u_system (
    .insn_i       (instr_rdata_i),
    .hit_o        (sy_hit),
    .illegal_o    (sy_illegal),
    .ecall_o      (sy_ecall),
    .ebrk_o       (sy_ebrk),
    .mret_o       (sy_mret),
    .wfi_flush_o  (sy_wfi),
    .csr_access_o (sy_csr_access),
    .csr_status_o (sy_csr_status),
    .regfile_we_o (sy_we),
    .csr_op_o     (sy_csr_op),
    .op_a_sel_o   (sy_op_a),
    .imm_a_sel_o  (sy_imm_a)
  );

  //////////////////////////////////////////////////////////////////////
  // merge: at most one group hits, unowned fields keep defaults
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    d_alu_op = ALU_SLTU;
    d_op_a   = OP_A_REGA_OR_FWD;
    d_op_b   = OP_B_REGB_OR_FWD;
    d_imm_b  = IMMB_I;
    if (cf_hit) begin
      d_alu_op = cf_alu_op;
      d_op_a   = cf_op_a;
      d_op_b   = cf_op_b;
      d_imm_b  = cf_imm_b;
    end else if (al_hit) begin
      d_alu_op = al_alu_op;
      d_op_a   = al_op_a;
      d_op_b   = al_op_b;
      d_imm_b  = al_imm_b;
    end else if (ls_hit) begin
      d_imm_b  = ls_imm_b;
    end else if (sy_hit) begin
      d_op_a   = sy_op_a;
    end
  end

  // group outputs are already low when their group misses
  assign d_illegal = ~(cf_hit | ls_hit | al_hit | sy_hit) | illegal_c_insn_i
                   | cf_illegal | ls_illegal | al_illegal | sy_illegal;

  // stall gating
  assign d_we     = ~deassert_we_i & (cf_we | ls_we | al_we | sy_we);
  assign d_mult   = ~deassert_we_i & al_mult;
  assign d_div    = ~deassert_we_i & al_div;
  assign d_req    = ~deassert_we_i & ls_req;
  assign d_jump   = ~deassert_we_i & cf_jump;
  assign d_branch = ~deassert_we_i & cf_branch;
  assign d_csr_op = deassert_we_i ? CSR_OP_NONE : sy_csr_op;

  //////////////////////////////////////////////////////////////////////
  // ID/EX control register, loads only on the strobe
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ex_valid_o            <= 1'b0;
      illegal_insn_o        <= 1'b0;
      ebrk_insn_o           <= 1'b0;
      mret_insn_o           <= 1'b0;
      ecall_insn_o          <= 1'b0;
      pipe_flush_o          <= 1'b0;
      alu_operator_o        <= ALU_SLTU;
      alu_op_a_mux_sel_o    <= OP_A_REGA_OR_FWD;
      alu_op_b_mux_sel_o    <= OP_B_REGB_OR_FWD;
      imm_a_mux_sel_o       <= IMMA_ZERO;
      imm_b_mux_sel_o       <= IMMB_I;
      mult_int_en_o         <= 1'b0;
      div_int_en_o          <= 1'b0;
      multdiv_operator_o    <= MD_OP_MULL;
      multdiv_signed_mode_o <= 2'b00;
      regfile_we_o          <= 1'b0;
      csr_access_o          <= 1'b0;
      csr_op_o              <= CSR_OP_NONE;
      csr_status_o          <= 1'b0;
      data_req_o            <= 1'b0;
      data_we_o             <= 1'b0;
      data_type_o           <= DATA_WORD;
      data_sign_extension_o <= 1'b0;
      jump_in_id_o          <= 1'b0;
      branch_in_id_o        <= 1'b0;
    end else begin
      ex_valid_o <= instr_valid_i;  // one cycle per strobe
      if (instr_valid_i) begin
        illegal_insn_o        <= d_illegal;
        ebrk_insn_o           <= sy_ebrk;
        mret_insn_o           <= sy_mret;
        ecall_insn_o          <= sy_ecall;
        pipe_flush_o          <= sy_wfi;
        alu_operator_o        <= d_alu_op;
        alu_op_a_mux_sel_o    <= d_op_a;
        alu_op_b_mux_sel_o    <= d_op_b;
        imm_a_mux_sel_o       <= sy_imm_a;
        imm_b_mux_sel_o       <= d_imm_b;
        mult_int_en_o         <= d_mult;
        div_int_en_o          <= d_div;
        multdiv_operator_o    <= al_md_op;
        multdiv_signed_mode_o <= al_md_sign;
        regfile_we_o          <= d_we;
        csr_access_o          <= sy_csr_access;
        csr_op_o              <= d_csr_op;
        csr_status_o          <= sy_csr_status;
        data_req_o            <= d_req;
        data_we_o             <= ls_we_mem;
        data_type_o           <= ls_type;
        data_sign_extension_o <= ls_sext;
        jump_in_id_o          <= d_jump;
        branch_in_id_o        <= d_branch;
      end
    end
  end

endmodule

//--- system_decoder.sv
// SYSTEM opcode: ECALL, EBREAK, MRET, WFI and CSR read-modify-write
// CSR address travels in the I immediate, no operand B select is driven
module system_decoder import decoder_pkg::*; (
  input  insn_t      insn_i,
  output logic       hit_o,
  output logic       illegal_o,
  output logic       ecall_o,
  output logic       ebrk_o,
  output logic       mret_o,
  output logic       wfi_flush_o,
  output logic       csr_access_o,
  output logic       csr_status_o,
  output logic       regfile_we_o,
  output csr_op_e    csr_op_o,
  output op_a_sel_e  op_a_sel_o,
  output imm_a_sel_e imm_a_sel_o
);

  logic [2:0]  funct3;
  logic [11:0] imm12;   // function code or CSR address

  assign funct3 = insn_i[14:12];
  assign imm12  = insn_i[31:20];
  assign hit_o  = (opcode_e'(insn_i[6:0]) == OPCODE_SYSTEM);

  always_comb begin
    illegal_o    = 1'b0;
    ecall_o      = 1'b0;
    ebrk_o       = 1'b0;
    mret_o       = 1'b0;
    wfi_flush_o  = 1'b0;
    csr_access_o = 1'b0;
    csr_status_o = 1'b0;
    regfile_we_o = 1'b0;
    csr_op_o     = CSR_OP_NONE;
    op_a_sel_o   = OP_A_REGA_OR_FWD;
    imm_a_sel_o  = IMMA_ZERO;

    if (hit_o) begin
      if (funct3 == 3'b000) begin
        case (imm12)
          12'h000: ecall_o     = 1'b1;
          12'h001: ebrk_o      = 1'b1;
          12'h302: mret_o      = 1'b1;
          12'h105: wfi_flush_o = 1'b1;  // wfi flushes the pipe
          default: illegal_o   = 1'b1;
        endcase
      end else begin
        csr_access_o = 1'b1;
        regfile_we_o = 1'b1;            // old CSR value to rd
        imm_a_sel_o  = IMMA_Z;
        if (funct3[2]) op_a_sel_o = OP_A_IMM;  // csrrwi/si/ci

        case (funct3[1:0])
          2'b01:   csr_op_o  = CSR_OP_WRITE;
          2'b10:   csr_op_o  = CSR_OP_SET;
          2'b11:   csr_op_o  = CSR_OP_CLEAR;
          default: illegal_o = 1'b1;    // funct3 100
        endcase

        // mstatus needs special handling in the controller
        csr_status_o = ~illegal_o && (imm12 == 12'h300);
      end
    end
  end

endmodule

//--- alu_decoder.sv
// LUI, AUIPC, OP-IMM and OP, including the RV32M rows of OP
// with RV32M = 0 the M rows decode illegal and never enable mult/div
module alu_decoder import decoder_pkg::*; #(
  parameter int unsigned RV32M = 1
) (
  input  insn_t      insn_i,
  output logic       hit_o,
  output logic       illegal_o,
  output logic       regfile_we_o,
  output alu_op_e    alu_operator_o,
  output op_a_sel_e  op_a_sel_o,
  output op_b_sel_e  op_b_sel_o,
  output imm_b_sel_e imm_b_sel_o,
  output logic       mult_en_o,
  output logic       div_en_o,
  output md_op_e     md_operator_o,
  output md_sign_t   md_signed_o
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       m_row;     // funct7 0000001 on OP

  assign opcode = opcode_e'(insn_i[6:0]);
  assign funct3 = insn_i[14:12];
  assign funct7 = insn_i[31:25];
  assign m_row  = (opcode == OPCODE_OP) && (funct7 == 7'b0000001);

  //////////////////////////////////////////////////////////////////////
  // base integer ops
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    hit_o          = 1'b1;
    illegal_o      = 1'b0;
    regfile_we_o   = 1'b1;   // every op of this group writes rd
    alu_operator_o = ALU_ADD;
    op_a_sel_o     = OP_A_REGA_OR_FWD;
    op_b_sel_o     = OP_B_IMM;
    imm_b_sel_o    = IMMB_I;

    case (opcode)
      OPCODE_LUI: begin
        op_a_sel_o  = OP_A_IMM;     // zero + U imm
        imm_b_sel_o = IMMB_U;
      end

      OPCODE_AUIPC: begin
        op_a_sel_o  = OP_A_CURRPC;  // pc + U imm
        imm_b_sel_o = IMMB_U;
      end

      OPCODE_OPIMM: begin
        case (funct3)
          3'b000: alu_operator_o = ALU_ADD;
          3'b010: alu_operator_o = ALU_SLTS;
          3'b011: alu_operator_o = ALU_SLTU;
          3'b100: alu_operator_o = ALU_XOR;
          3'b110: alu_operator_o = ALU_OR;
          3'b111: alu_operator_o = ALU_AND;
          3'b001: begin
            alu_operator_o = ALU_SLL;
            illegal_o      = (funct7 != 7'b0000000);
          end
          default: begin // 101 is the right shifts
            alu_operator_o = funct7[5] ? ALU_SRA : ALU_SRL;
            illegal_o      = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
          end
        endcase
      end

      OPCODE_OP: begin
        op_b_sel_o = OP_B_REGB_OR_FWD;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: alu_operator_o = ALU_ADD;
          {7'b0100000, 3'b000}: alu_operator_o = ALU_SUB;
          {7'b0000000, 3'b010}: alu_operator_o = ALU_SLTS;
          {7'b0000000, 3'b011}: alu_operator_o = ALU_SLTU;
          {7'b0000000, 3'b100}: alu_operator_o = ALU_XOR;
          {7'b0000000, 3'b110}: alu_operator_o = ALU_OR;
          {7'b0000000, 3'b111}: alu_operator_o = ALU_AND;
          {7'b0000000, 3'b001}: alu_operator_o = ALU_SLL;
          {7'b0000000, 3'b101}: alu_operator_o = ALU_SRL;
          {7'b0100000, 3'b101}: alu_operator_o = ALU_SRA;
          default: illegal_o = ~m_row || (RV32M == 0);  // M rows keep ADD
        endcase
      end

      default: begin
        hit_o        = 1'b0;
        regfile_we_o = 1'b0;
        alu_operator_o = ALU_SLTU;
        op_b_sel_o   = OP_B_REGB_OR_FWD;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // RV32M rows with funct3 picking operator and operand signs
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    mult_en_o     = 1'b0;
    div_en_o      = 1'b0;
    md_operator_o = MD_OP_MULL;
    md_signed_o   = 2'b00;

    if (m_row && RV32M != 0) begin
      mult_en_o = ~funct3[2];
      div_en_o  = funct3[2];
      case (funct3)
        3'b000: md_operator_o = MD_OP_MULL;   // mul
        3'b001: begin                         // mulh
          md_operator_o = MD_OP_MULH;
          md_signed_o   = 2'b11;
        end
        3'b010: begin                         // mulhsu, rs1 signed only
          md_operator_o = MD_OP_MULH;
          md_signed_o   = 2'b10;
        end
        3'b011: md_operator_o = MD_OP_MULH;   // mulhu
        3'b100: begin                         // div
          md_operator_o = MD_OP_DIV;
          md_signed_o   = 2'b11;
        end
        3'b101: md_operator_o = MD_OP_DIV;    // divu
        3'b110: begin                         // rem
          md_operator_o = MD_OP_REM;
          md_signed_o   = 2'b11;
        end
        default: md_operator_o = MD_OP_REM;   // remu
      endcase
    end
  end

endmodule

//--- lsu_decoder.sv
// loads and stores, immediate offset forms only
// address add itself is not set here, see the merge in the top level
module lsu_decoder import decoder_pkg::*; (
  input  insn_t      insn_i,
  output logic       hit_o,
  output logic       illegal_o,
  output logic       data_req_o,
  output logic       data_we_o,
  output logic       regfile_we_o,
  output data_type_e data_type_o,
  output logic       data_sign_ext_o,
  output imm_b_sel_e imm_b_sel_o
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic       size_bad;  // size field 11 has no RV32 access

  assign opcode   = opcode_e'(insn_i[6:0]);
  assign funct3   = insn_i[14:12];
  assign size_bad = (funct3[1:0] == 2'b11);

  always_comb begin
    hit_o           = 1'b1;
    illegal_o       = 1'b0;
    data_req_o      = 1'b0;
    data_we_o       = 1'b0;
    regfile_we_o    = 1'b0;
    data_sign_ext_o = 1'b0;
    imm_b_sel_o     = IMMB_I;

    // access size, funct3 bits 1:0
    case (funct3[1:0])
      2'b00:   data_type_o = DATA_BYTE;
      2'b01:   data_type_o = DATA_HALF;
      default: data_type_o = DATA_WORD;
    endcase

    case (opcode)
      OPCODE_STORE: begin
        imm_b_sel_o = IMMB_S;
        illegal_o   = funct3[2] | size_bad;
        data_req_o  = ~illegal_o;
        data_we_o   = ~illegal_o;
      end

      OPCODE_LOAD: begin
        data_sign_ext_o = ~funct3[2];   // LBU, LHU zero extend
        illegal_o       = size_bad | (funct3 == 3'b110);
        data_req_o      = ~illegal_o;
        regfile_we_o    = ~illegal_o;
      end

      default: hit_o = 1'b0;
    endcase
  end

endmodule

//--- ctrl_flow_decoder.sv
// JAL, JALR and conditional branches, both ALU phases
// jump_mux_i high selects the target add, branch_mux_i high the compare
module ctrl_flow_decoder import decoder_pkg::*; (
  input  insn_t      insn_i,
  input  logic       jump_mux_i,
  input  logic       branch_mux_i,
  output logic       hit_o,
  output logic       illegal_o,
  output logic       jump_o,
  output logic       branch_o,
  output logic       regfile_we_o,
  output alu_op_e    alu_operator_o,
  output op_a_sel_e  op_a_sel_o,
  output op_b_sel_e  op_b_sel_o,
  output imm_b_sel_e imm_b_sel_o
);

  opcode_e    opcode;
  logic [2:0] funct3;

  assign opcode = opcode_e'(insn_i[6:0]);
  assign funct3 = insn_i[14:12];

  always_comb begin
    hit_o          = 1'b1;
    illegal_o      = 1'b0;
    jump_o         = 1'b0;
    branch_o       = 1'b0;
    regfile_we_o   = 1'b0;
    alu_operator_o = ALU_SLTU;
    op_a_sel_o     = OP_A_REGA_OR_FWD;
    op_b_sel_o     = OP_B_REGB_OR_FWD;
    imm_b_sel_o    = IMMB_I;

    case (opcode)
      OPCODE_JAL, OPCODE_JALR: begin
        jump_o         = 1'b1;
        alu_operator_o = ALU_ADD;
        op_b_sel_o     = OP_B_IMM;
        if (jump_mux_i) begin   // target phase
          if (opcode == OPCODE_JAL) begin
            op_a_sel_o  = OP_A_CURRPC;   // pc + UJ imm
            imm_b_sel_o = IMMB_UJ;
          end else begin
            imm_b_sel_o = IMMB_I;        // rs1 + I imm
          end
        end else begin          // link phase
          op_a_sel_o   = OP_A_CURRPC;
          imm_b_sel_o  = IMMB_PCINCR;
          regfile_we_o = 1'b1;           // rd = pc + 4
        end
        if (opcode == OPCODE_JALR && funct3 != 3'b000) begin
          jump_o       = 1'b0;
          regfile_we_o = 1'b0;
          illegal_o    = 1'b1;
        end
      end

      OPCODE_BRANCH: begin
        branch_o = 1'b1;
        if (branch_mux_i) begin // compare phase
          case (funct3)
            3'b000:  alu_operator_o = ALU_EQ;
            3'b001:  alu_operator_o = ALU_NE;
            3'b100:  alu_operator_o = ALU_LTS;
            3'b101:  alu_operator_o = ALU_GES;
            3'b110:  alu_operator_o = ALU_LTU;
            default: alu_operator_o = ALU_GEU;
          endcase
        end else begin          // target phase, pc + SB imm
          alu_operator_o = ALU_ADD;
          op_a_sel_o     = OP_A_CURRPC;
          op_b_sel_o     = OP_B_IMM;
          imm_b_sel_o    = IMMB_SB;
        end
        illegal_o = (funct3[2:1] == 2'b01);  // 010, 011 unassigned
      end

      default: hit_o = 1'b0;
    endcase
  end

endmodule

//--- decoder_pkg.sv
// types and encodings shared by the rv32 ID stage decoder
// values must match the ALU, LSU, mult/div and CSR units of the core
package decoder_pkg;

  typedef logic [31:0] insn_t;     // raw instruction word
  typedef logic [1:0]  md_sign_t;  // {op a signed, op b signed}

  //////////////////////////////////////////////////////////////////////
  // major opcodes, instruction bits 6:0
  //////////////////////////////////////////////////////////////////////
  typedef enum logic [6:0] {
    OPCODE_LOAD   = 7'h03,
    OPCODE_OPIMM  = 7'h13,
    OPCODE_AUIPC  = 7'h17,
    OPCODE_STORE  = 7'h23,
    OPCODE_OP     = 7'h33,
    OPCODE_LUI    = 7'h37,
    OPCODE_BRANCH = 7'h63,
    OPCODE_JALR   = 7'h67,
    OPCODE_JAL    = 7'h6f,
    OPCODE_SYSTEM = 7'h73
  } opcode_e;

  //////////////////////////////////////////////////////////////////////
  // ALU operators and operand muxing
  //////////////////////////////////////////////////////////////////////
  localparam int ALU_OP_WIDTH = 6;

  typedef enum logic [ALU_OP_WIDTH-1:0] {
    ALU_ADD  = 6'b011000,
    ALU_SUB  = 6'b011001,
    ALU_XOR  = 6'b101111,
    ALU_OR   = 6'b101110,
    ALU_AND  = 6'b010101,
    ALU_SRA  = 6'b100100,
    ALU_SRL  = 6'b100101,
    ALU_SLL  = 6'b100111,
    ALU_LTS  = 6'b000000,  // branch compares
    ALU_LTU  = 6'b000001,
    ALU_SLTS = 6'b000010,  // set-less-than, result to rd
    ALU_SLTU = 6'b000011,
    ALU_GES  = 6'b001010,
    ALU_GEU  = 6'b001011,
    ALU_EQ   = 6'b001100,
    ALU_NE   = 6'b001101
  } alu_op_e;

  typedef enum logic [2:0] {
    OP_A_REGA_OR_FWD = 3'b000,
    OP_A_CURRPC      = 3'b001,
    OP_A_IMM         = 3'b010
  } op_a_sel_e;

  typedef enum logic [2:0] {
    OP_B_REGB_OR_FWD = 3'b000,
    OP_B_IMM         = 3'b010
  } op_b_sel_e;

  typedef enum logic [0:0] {
    IMMA_Z    = 1'b0,  // zero-extended rs1 field, CSR immediate forms
    IMMA_ZERO = 1'b1
  } imm_a_sel_e;

  typedef enum logic [3:0] {
    IMMB_I      = 4'b0000,
    IMMB_S      = 4'b0001,
    IMMB_U      = 4'b0010,
    IMMB_PCINCR = 4'b0011,  // 4, for link address
    IMMB_UJ     = 4'b1100,
    IMMB_SB     = 4'b1101
  } imm_b_sel_e;

  //////////////////////////////////////////////////////////////////////
  // mult/div, CSR and LSU controls
  //////////////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {
    MD_OP_MULL = 2'b00,
    MD_OP_MULH = 2'b01,
    MD_OP_DIV  = 2'b10,
    MD_OP_REM  = 2'b11
  } md_op_e;

  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  typedef enum logic [1:0] {
    DATA_WORD = 2'b00,
    DATA_HALF = 2'b01,
    DATA_BYTE = 2'b10
  } data_type_e;

endpackage
